// ==== rtl/sys_reg_cfg.svh ====
//////////////////////////////
// Fixed 32-bit bus with 8 word slots
// Lane count must match the transceiver pin widths
//////////////////////////////

`ifndef SYS_REG_CFG_SVH
`define SYS_REG_CFG_SVH

// AXI4-Lite data width in bits
`define SYS_REG_DATA_W 32

// AXI4-Lite byte address width, covers 8 words
`define SYS_REG_ADDR_W 5

// Byte offset bits below the word index
`define SYS_REG_ADDR_LSB 2

// Word slot index width
`define SYS_REG_IDX_W 3

// Transceiver lanes fed by the per-lane control fields
`define SYS_REG_LANES 4

`endif

// ==== rtl/sys_reg_pkg.sv ====
//////////////////////////////
// Bus types and register layouts
//////////////////////////////

`include "sys_reg_cfg.svh"

package sys_reg_pkg;

  // AXI4-Lite bus fields
  typedef logic [`SYS_REG_ADDR_W-1:0]   axi_addr_t;
  typedef logic [`SYS_REG_DATA_W-1:0]   axi_data_t;
  typedef logic [`SYS_REG_DATA_W/8-1:0] axi_strb_t;
  typedef logic [1:0]                   axi_resp_t;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  // Word slot index and the register map
  typedef logic [`SYS_REG_IDX_W-1:0] reg_idx_t;

  typedef enum reg_idx_t {
    SLOT_SRIO_CTRL = 3'd0,
    SLOT_SRIO_STAT = 3'd1,
    SLOT_SINK_DEST = 3'd2,
    SLOT_SCRATCH0  = 3'd3,
    SLOT_SCRATCH1  = 3'd4,
    SLOT_SCRATCH2  = 3'd5,
    SLOT_SCRATCH3  = 3'd6,
    SLOT_UNMAPPED  = 3'd7
  } reg_slot_e;

  // Single-cycle write request toward the register bank
  typedef struct packed {
    logic      valid;
    reg_idx_t  idx;
    axi_data_t data;
    axi_strb_t strb;
  } reg_wr_t;

  // Slot 0 control fields, low 20 bits, MSB first
  typedef struct packed {
    logic       rxlpmen;
    logic [4:0] txpostcursor;
    logic [4:0] txprecursor;
    logic [3:0] diffctrl;
    logic [2:0] loopback;
    logic       swrite_bypass;
    logic       reset;
  } srio_ctrl_t;

  // Slot 1 status word
  typedef struct packed {
    logic [15:0] device_id;
    logic [8:0]  zero;
    logic        disperr;
    logic        notintable;
    logic        port_error;
    logic        mode_1x;
    logic        clk_lock;
    logic        port_init;
    logic        link_init;
  } srio_stat_t;

endpackage

// ==== rtl/axil_write_ctrl.sv ====
//////////////////////////////
// Needs AW and W presented together
// One write outstanding, always OKAY
//////////////////////////////

`timescale 1ns/1ps

`include "sys_reg_cfg.svh"

module axil_write_ctrl (
  input  logic                  S_AXI_ACLK,
  input  logic                  S_AXI_ARESETN,
  // Write address channel
  input  sys_reg_pkg::axi_addr_t awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  // Write data channel
  input  sys_reg_pkg::axi_data_t wdata,
  input  sys_reg_pkg::axi_strb_t wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  // Write response channel
  output sys_reg_pkg::axi_resp_t bresp,
  output logic                  bvalid,
  input  logic                  bready,
  // Request to the register bank
  output sys_reg_pkg::reg_wr_t   wr_req
);

  import sys_reg_pkg::*;

  // Shared ready pulse for AW and W
  logic accept_q;
  // Both channels complete on this edge
  logic wr_hs;

  assign awready = accept_q;
  assign wready  = accept_q;
  assign wr_hs   = accept_q && awvalid && wvalid;

  //////////////////////////////
  // Ready pulse and response state
  //////////////////////////////
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      accept_q <= 1'b0;
      bvalid   <= 1'b0;
    end
    else
    begin
      // One-cycle pulse, held off while a response waits
      accept_q <= !accept_q && awvalid && wvalid && !bvalid;
      if (wr_hs)
      begin
        bvalid <= 1'b1;
      end
      else if (bvalid && bready)
      begin
        bvalid <= 1'b0;
      end
    end
  end

  // Error responses are never produced
  assign bresp = RESP_OKAY;

  //////////////////////////////
  // Register bank request
  //////////////////////////////
  always_comb
  begin
    wr_req.valid = wr_hs;
    // Word index from the bits above the byte offset
    wr_req.idx   = awaddr[`SYS_REG_ADDR_W-1:`SYS_REG_ADDR_LSB];
    wr_req.data  = wdata;
    wr_req.strb  = wstrb;
  end

endmodule

// ==== rtl/axil_read_ctrl.sv ====
//////////////////////////////
// One read outstanding, always OKAY
//////////////////////////////

`timescale 1ns/1ps

`include "sys_reg_cfg.svh"

module axil_read_ctrl (
  input  logic                   S_AXI_ACLK,
  input  logic                   S_AXI_ARESETN,
  // Read address channel
  input  sys_reg_pkg::axi_addr_t araddr,
  input  logic                   arvalid,
  output logic                   arready,
  // Read data channel
  output sys_reg_pkg::axi_data_t rdata,
  output sys_reg_pkg::axi_resp_t rresp,
  output logic                   rvalid,
  input  logic                   rready,
  // Register bank read port
  output sys_reg_pkg::reg_idx_t  rd_idx,
  input  sys_reg_pkg::axi_data_t rd_data
);

  import sys_reg_pkg::*;

  // Address taken, data capture on the next edge
  logic rd_pend;
  logic ar_hs;

  assign ar_hs = arready && arvalid;

  //////////////////////////////
  // Handshake state
  //////////////////////////////
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      arready <= 1'b0;
      rd_pend <= 1'b0;
      rvalid  <= 1'b0;
    end
    else
    begin
      // No new address while a read is in flight
      arready <= !arready && arvalid && !rd_pend && !rvalid;
      rd_pend <= ar_hs;
      if (rd_pend)
      begin
        rvalid <= 1'b1;
      end
      else if (rvalid && rready)
      begin
        rvalid <= 1'b0;
      end
    end
  end

  // Index and read data payload
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (ar_hs)
    begin
      rd_idx <= araddr[`SYS_REG_ADDR_W-1:`SYS_REG_ADDR_LSB];
    end
    // rdata holds until the next read completes
    if (rd_pend)
    begin
      rdata <= rd_data;
    end
  end

  assign rresp = RESP_OKAY;

endmodule

// ==== rtl/srio_reg_bank.sv ====
//////////////////////////////
// Slots 1 and 7 ignore writes
//////////////////////////////

`timescale 1ns/1ps

module srio_reg_bank (
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  // Write request from the write channel
  input  sys_reg_pkg::reg_wr_t     wr_req,
  // Combinational read port
  input  sys_reg_pkg::reg_idx_t    rd_idx,
  output sys_reg_pkg::axi_data_t   rd_data,
  // Transceiver side
  input  sys_reg_pkg::srio_stat_t  srio_stat,
  output sys_reg_pkg::srio_ctrl_t  srio_ctrl,
  output logic [1:0]               adc_sw_dest
);

  import sys_reg_pkg::*;

  // Stored words
  axi_data_t ctrl_q;
  axi_data_t sink_q;
  axi_data_t scratch_q [4];

  // Scratch array selects, relative to the first scratch slot
  logic [1:0] scr_wr_sel;
  logic [1:0] scr_rd_sel;

  assign scr_wr_sel = 2'(wr_req.idx - reg_idx_t'(SLOT_SCRATCH0));
  assign scr_rd_sel = 2'(rd_idx - reg_idx_t'(SLOT_SCRATCH0));

  // Keep old bytes where the strobe is low
  function automatic axi_data_t byte_merge(
    input axi_data_t old_w,
    input axi_data_t new_w,
    input axi_strb_t strb
  );
    axi_data_t res;
    res = old_w;
    for (int b = 0; b < $bits(axi_strb_t); b++)
    begin
      if (strb[b])
      begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  //////////////////////////////
  // Register writes
  //////////////////////////////
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      ctrl_q <= '0;
      sink_q <= '0;
      for (int i = 0; i < 4; i++)
      begin
        scratch_q[i] <= '0;
      end
    end
    else if (wr_req.valid)
    begin
      case (reg_slot_e'(wr_req.idx))
        SLOT_SRIO_CTRL:
        begin
          ctrl_q <= byte_merge(ctrl_q, wr_req.data, wr_req.strb);
        end
        SLOT_SINK_DEST:
        begin
          sink_q <= byte_merge(sink_q, wr_req.data, wr_req.strb);
        end
        SLOT_SCRATCH0, SLOT_SCRATCH1, SLOT_SCRATCH2, SLOT_SCRATCH3:
        begin
          scratch_q[scr_wr_sel] <= byte_merge(scratch_q[scr_wr_sel], wr_req.data,
                                              wr_req.strb);
        end
        // Status and unmapped slots have no storage
        default:
        begin
        end
      endcase
    end
  end

  //////////////////////////////
  // Read mux
  //////////////////////////////
  always_comb
  begin
    case (reg_slot_e'(rd_idx))
      SLOT_SRIO_CTRL:
        rd_data = ctrl_q;
      SLOT_SRIO_STAT:
        rd_data = axi_data_t'(srio_stat);
      SLOT_SINK_DEST:
        rd_data = sink_q;
      SLOT_SCRATCH0, SLOT_SCRATCH1, SLOT_SCRATCH2, SLOT_SCRATCH3:
        rd_data = scratch_q[scr_rd_sel];
      default:
        rd_data = '0;
    endcase
  end

  // Control fields sit in the low bits of slot 0
  assign srio_ctrl   = srio_ctrl_t'(ctrl_q[$bits(srio_ctrl_t)-1:0]);
  // Sink select in the two low bits of slot 2
  assign adc_sw_dest = sink_q[1:0];

endmodule

// ==== rtl/sys_reg.sv ====
//////////////////////////////
// Per-lane fields are copied to all lanes
//////////////////////////////

`timescale 1ns/1ps

`include "sys_reg_cfg.svh"

module sys_reg (
  input  logic                   S_AXI_ACLK,
  input  logic                   S_AXI_ARESETN,
  // AXI4-Lite write channels
  input  sys_reg_pkg::axi_addr_t s_axi_awaddr,
  input  logic                   s_axi_awvalid,
  output logic                   s_axi_awready,
  input  sys_reg_pkg::axi_data_t s_axi_wdata,
  input  sys_reg_pkg::axi_strb_t s_axi_wstrb,
  input  logic                   s_axi_wvalid,
  output logic                   s_axi_wready,
  output sys_reg_pkg::axi_resp_t s_axi_bresp,
  output logic                   s_axi_bvalid,
  input  logic                   s_axi_bready,
  // AXI4-Lite read channels
  input  sys_reg_pkg::axi_addr_t s_axi_araddr,
  input  logic                   s_axi_arvalid,
  output logic                   s_axi_arready,
  output sys_reg_pkg::axi_data_t s_axi_rdata,
  output sys_reg_pkg::axi_resp_t s_axi_rresp,
  output logic                   s_axi_rvalid,
  input  logic                   s_axi_rready,
  // Transceiver control
  output logic                   srio_reset,
  output logic                   swrite_bypass,
  output logic [11:0]            srio_loopback,
  output logic [3:0]             gt_diffctrl,
  output logic [19:0]            gt_txprecursor,
  output logic [19:0]            gt_txpostcursor,
  output logic [3:0]             gt_rxlpmen,
  // ADC data sink destination
  output logic                   adc_sw_dest0,
  output logic                   adc_sw_dest1,
  // Transceiver status
  input  logic                   srio_mode_1x,
  input  logic                   srio_clk_out_lock,
  input  logic                   srio_port_initialized,
  input  logic                   srio_link_initialized,
  input  logic                   gtrx_disperr_or,
  input  logic                   gtrx_notintable_or,
  input  logic                   port_error,
  input  logic [15:0]            device_id
);

  import sys_reg_pkg::*;

  reg_wr_t    wr_req;
  reg_idx_t   rd_idx;
  axi_data_t  rd_data;
  srio_stat_t srio_stat;
  srio_ctrl_t srio_ctrl;
  logic [1:0] adc_sw_dest;

  //////////////////////////////
  // Status packing
  //////////////////////////////
  always_comb
  begin
    srio_stat            = '0;
    srio_stat.device_id  = device_id;
    srio_stat.disperr    = gtrx_disperr_or;
    srio_stat.notintable = gtrx_notintable_or;
    srio_stat.port_error = port_error;
    srio_stat.mode_1x    = srio_mode_1x;
    srio_stat.clk_lock   = srio_clk_out_lock;
    srio_stat.port_init  = srio_port_initialized;
    srio_stat.link_init  = srio_link_initialized;
  end

  axil_write_ctrl i_axil_write_ctrl (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .awaddr        (s_axi_awaddr),
    .awvalid       (s_axi_awvalid),
    .awready       (s_axi_awready),
    .wdata         (s_axi_wdata),
    .wstrb         (s_axi_wstrb),
    .wvalid        (s_axi_wvalid),
    .wready        (s_axi_wready),
    .bresp         (s_axi_bresp),
    .bvalid        (s_axi_bvalid),
    .bready        (s_axi_bready),
    .wr_req        (wr_req)
  );

  axil_read_ctrl i_axil_read_ctrl (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .araddr        (s_axi_araddr),
    .arvalid       (s_axi_arvalid),
    .arready       (s_axi_arready),
    .rdata         (s_axi_rdata),
    .rresp         (s_axi_rresp),
    .rvalid        (s_axi_rvalid),
    .rready        (s_axi_rready),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data)
  );

  srio_reg_bank i_srio_reg_bank (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr_req        (wr_req),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data),
    .srio_stat     (srio_stat),
    .srio_ctrl     (srio_ctrl),
    .adc_sw_dest   (adc_sw_dest)
  );

  //////////////////////////////
  // Control pin fan-out
  //////////////////////////////
  assign srio_reset      = srio_ctrl.reset;
  assign swrite_bypass   = srio_ctrl.swrite_bypass;
  assign srio_loopback   = {`SYS_REG_LANES{srio_ctrl.loopback}};
  // Diffctrl is a single 4-bit field, not per lane
  assign gt_diffctrl     = srio_ctrl.diffctrl;
  assign gt_txprecursor  = {`SYS_REG_LANES{srio_ctrl.txprecursor}};
  assign gt_txpostcursor = {`SYS_REG_LANES{srio_ctrl.txpostcursor}};
  assign gt_rxlpmen      = {`SYS_REG_LANES{srio_ctrl.rxlpmen}};

  assign adc_sw_dest0    = adc_sw_dest[0];
  assign adc_sw_dest1    = adc_sw_dest[1];

endmodule

// ==== sim/tb_sys_reg.sv ====
//////////////////////////////
// Expects one response at a time, AW and W offered together
// Cycle budget grows with the number of table rows
//////////////////////////////

`timescale 1ns/1ps

`include "sys_reg_cfg.svh"

module tb_sys_reg;

  import sys_reg_pkg::*;

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_STAT} op_e;

  // One stimulus row, exp only used by reads
  typedef struct packed {
    op_e       op;
    axi_addr_t addr;
    axi_data_t data;
    axi_strb_t strb;
    axi_data_t exp;
  } row_t;

  // Unmapped slot, offered while a response is pending
  localparam axi_addr_t PROBE_ADDR = 5'h1C;

  logic        S_AXI_ACLK = 1'b0;
  logic        S_AXI_ARESETN;
  axi_addr_t   s_axi_awaddr;
  logic        s_axi_awvalid;
  logic        s_axi_awready;
  axi_data_t   s_axi_wdata;
  axi_strb_t   s_axi_wstrb;
  logic        s_axi_wvalid;
  logic        s_axi_wready;
  axi_resp_t   s_axi_bresp;
  logic        s_axi_bvalid;
  logic        s_axi_bready;
  axi_addr_t   s_axi_araddr;
  logic        s_axi_arvalid;
  logic        s_axi_arready;
  axi_data_t   s_axi_rdata;
  axi_resp_t   s_axi_rresp;
  logic        s_axi_rvalid;
  logic        s_axi_rready;
  logic        srio_reset;
  logic        swrite_bypass;
  logic [11:0] srio_loopback;
  logic [3:0]  gt_diffctrl;
  logic [19:0] gt_txprecursor;
  logic [19:0] gt_txpostcursor;
  logic [3:0]  gt_rxlpmen;
  logic        adc_sw_dest0;
  logic        adc_sw_dest1;
  logic        srio_mode_1x;
  logic        srio_clk_out_lock;
  logic        srio_port_initialized;
  logic        srio_link_initialized;
  logic        gtrx_disperr_or;
  logic        gtrx_notintable_or;
  logic        port_error;
  logic [15:0] device_id;

  row_t        rows[$];
  int          seed = 32'hc716_6490;
  int unsigned cycles = 0;
  int unsigned cycle_limit = 0;

  sys_reg i_sys_reg (.*);

  // 100 ns clock
  always #50 S_AXI_ACLK = ~S_AXI_ACLK;

  //////////////////////////////
  // Run time limit
  //////////////////////////////
  always @(posedge S_AXI_ACLK)
  begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles > cycle_limit)
    begin
      $display("Timeout after %0d cycles, the run did not finish", cycles);
      $display("TB FAILED");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
    if (got !== exp)
    begin
      $display("mismatch at %0d ns: %s, got %0h expected %0h", $time, msg, got, exp);
      $display("TB FAILED");
      $fatal(1, "Stopped at the first error");
    end
  endtask

  // Strobed bytes replace, the rest keep the old value
  function automatic axi_data_t apply_strobes(axi_data_t old_w, axi_data_t new_w,
                                              axi_strb_t strb);
    axi_data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++)
    begin
      if (strb[b])
      begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // Pins against the slot 0 and slot 2 models, lane fields copied four times
  task automatic check_pins(input axi_data_t ctrl, input axi_data_t sink);
    check({srio_reset, swrite_bypass, srio_loopback, gt_diffctrl, gt_txprecursor,
           gt_txpostcursor, gt_rxlpmen, adc_sw_dest1, adc_sw_dest0},
          {ctrl[0], ctrl[1], {4{ctrl[4:2]}}, ctrl[8:5], {4{ctrl[13:9]}},
           {4{ctrl[18:14]}}, {4{ctrl[19]}}, sink[1], sink[0]}, "control pins");
  endtask

  // Status word layout split onto the transceiver inputs
  task automatic set_status(input axi_data_t word);
    device_id             = word[31:16];
    gtrx_disperr_or       = word[6];
    gtrx_notintable_or    = word[5];
    port_error            = word[4];
    srio_mode_1x          = word[3];
    srio_clk_out_lock     = word[2];
    srio_port_initialized = word[1];
    srio_link_initialized = word[0];
    @(posedge S_AXI_ACLK);
    #1;
  endtask

  //////////////////////////////
  // Bus tasks, entered 1 ns after a rising edge
  //////////////////////////////
  task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb);
    int unsigned delay;
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    // Shared ready pulse for AW and W
    do
    begin
      @(negedge S_AXI_ACLK);
      check(64'(s_axi_wready), 64'(s_axi_awready), "wready with awready");
    end
    while (!s_axi_awready);
    @(posedge S_AXI_ACLK);
    #1;
    // Second write stays offered, must not be taken
    s_axi_awaddr = PROBE_ADDR;
    s_axi_wdata  = '1;
    delay = $random(seed) & 32'd7;
    repeat (delay + 1)
    begin
      @(negedge S_AXI_ACLK);
      check(64'(s_axi_bvalid), 64'(1'b1), "bvalid held until bready");
      check(64'(s_axi_bresp), 64'(RESP_OKAY), "bresp");
      check(64'(s_axi_awready), 64'(1'b0), "awready while bvalid pending");
    end
    @(posedge S_AXI_ACLK);
    #1;
    s_axi_bready  = 1'b1;
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    @(negedge S_AXI_ACLK);
    check(64'(s_axi_bvalid), 64'(1'b1), "bvalid at bready");
    @(posedge S_AXI_ACLK);
    #1;
    s_axi_bready = 1'b0;
    @(negedge S_AXI_ACLK);
    check(64'(s_axi_bvalid), 64'(1'b0), "bvalid after acceptance");
    @(posedge S_AXI_ACLK);
    #1;
  endtask

  task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
    int unsigned delay;
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    do
    begin
      @(negedge S_AXI_ACLK);
    end
    while (!s_axi_arready);
    @(posedge S_AXI_ACLK);
    #1;
    // Second read stays offered, must not be taken
    s_axi_araddr = PROBE_ADDR;
    @(negedge S_AXI_ACLK);
    check(64'(s_axi_rvalid), 64'(1'b0), "rvalid one cycle after arready");
    @(negedge S_AXI_ACLK);
    check(64'(s_axi_rvalid), 64'(1'b1), "rvalid two cycles after arready");
    data = s_axi_rdata;
    delay = $random(seed) & 32'd7;
    repeat (delay + 1)
    begin
      check(64'(s_axi_rvalid), 64'(1'b1), "rvalid held until rready");
      check(64'(s_axi_rdata), 64'(data), "rdata stable while rvalid");
      check(64'(s_axi_rresp), 64'(RESP_OKAY), "rresp");
      check(64'(s_axi_arready), 64'(1'b0), "arready while rvalid pending");
      @(negedge S_AXI_ACLK);
    end
    @(posedge S_AXI_ACLK);
    #1;
    s_axi_rready  = 1'b1;
    s_axi_arvalid = 1'b0;
    @(negedge S_AXI_ACLK);
    check(64'(s_axi_rdata), 64'(data), "rdata at rready");
    @(posedge S_AXI_ACLK);
    #1;
    s_axi_rready = 1'b0;
    @(negedge S_AXI_ACLK);
    check(64'(s_axi_rvalid), 64'(1'b0), "rvalid after acceptance");
    @(posedge S_AXI_ACLK);
    #1;
  endtask

  task automatic add_row(op_e op, axi_addr_t addr, axi_data_t data, axi_strb_t strb,
                         axi_data_t exp);
    rows.push_back('{op, addr, data, strb, exp});
  endtask

  //////////////////////////////
  // Stimulus table
  //////////////////////////////
  task automatic build_table();
    // Reset values
    add_row(OP_READ,  5'h00, 32'h0,         4'h0, 32'h0);
    add_row(OP_READ,  5'h08, 32'h0,         4'h0, 32'h0);
    add_row(OP_READ,  5'h0C, 32'h0,         4'h0, 32'h0);
    add_row(OP_READ,  5'h10, 32'h0,         4'h0, 32'h0);
    add_row(OP_READ,  5'h14, 32'h0,         4'h0, 32'h0);
    add_row(OP_READ,  5'h18, 32'h0,         4'h0, 32'h0);
    // Control word, full write then byte merges
    add_row(OP_WRITE, 5'h00, 32'h000A_B3C6, 4'hF, 32'h0);
    add_row(OP_READ,  5'h00, 32'h0,         4'h0, 32'h000A_B3C6);
    add_row(OP_WRITE, 5'h00, 32'hA5A5_1234, 4'h2, 32'h0);
    add_row(OP_READ,  5'h00, 32'h0,         4'h0, 32'h000A_12C6);
    add_row(OP_WRITE, 5'h00, 32'h5A06_7890, 4'h5, 32'h0);
    add_row(OP_READ,  5'h00, 32'h0,         4'h0, 32'h0006_1290);
    add_row(OP_WRITE, 5'h00, 32'h3C00_0000, 4'h8, 32'h0);
    add_row(OP_READ,  5'h00, 32'h0,         4'h0, 32'h3C06_1290);
    // Status word, writes to it have no effect
    add_row(OP_STAT,  5'h00, 32'hBEEF_0055, 4'h0, 32'h0);
    add_row(OP_READ,  5'h04, 32'h0,         4'h0, 32'hBEEF_0055);
    add_row(OP_STAT,  5'h00, 32'h1234_002A, 4'h0, 32'h0);
    add_row(OP_WRITE, 5'h04, 32'hFFFF_FFFF, 4'hF, 32'h0);
    add_row(OP_READ,  5'h04, 32'h0,         4'h0, 32'h1234_002A);
    add_row(OP_READ,  5'h00, 32'h0,         4'h0, 32'h3C06_1290);
    // Sink destination
    add_row(OP_WRITE, 5'h08, 32'h0000_0001, 4'hF, 32'h0);
    add_row(OP_READ,  5'h08, 32'h0,         4'h0, 32'h0000_0001);
    add_row(OP_WRITE, 5'h08, 32'hFFFF_FF02, 4'h1, 32'h0);
    add_row(OP_READ,  5'h08, 32'h0,         4'h0, 32'h0000_0002);
    add_row(OP_WRITE, 5'h08, 32'hFFFF_FF03, 4'h3, 32'h0);
    add_row(OP_READ,  5'h08, 32'h0,         4'h0, 32'h0000_FF03);
    // Scratch words
    add_row(OP_WRITE, 5'h0C, 32'h1111_1111, 4'hF, 32'h0);
    add_row(OP_WRITE, 5'h10, 32'h2222_2222, 4'hF, 32'h0);
    add_row(OP_WRITE, 5'h14, 32'h3333_3333, 4'hF, 32'h0);
    add_row(OP_WRITE, 5'h18, 32'h4444_4444, 4'hF, 32'h0);
    add_row(OP_WRITE, 5'h18, 32'hAB00_0000, 4'h8, 32'h0);
    add_row(OP_READ,  5'h0C, 32'h0,         4'h0, 32'h1111_1111);
    add_row(OP_READ,  5'h10, 32'h0,         4'h0, 32'h2222_2222);
    add_row(OP_READ,  5'h14, 32'h0,         4'h0, 32'h3333_3333);
    add_row(OP_READ,  5'h18, 32'h0,         4'h0, 32'hAB44_4444);
    // Unmapped slot
    add_row(OP_WRITE, 5'h1C, 32'hDEAD_BEEF, 4'hF, 32'h0);
    add_row(OP_READ,  5'h1C, 32'h0,         4'h0, 32'h0);
    add_row(OP_READ,  5'h0C, 32'h0,         4'h0, 32'h1111_1111);
    add_row(OP_STAT,  5'h00, 32'hFFFF_007F, 4'h0, 32'h0);
    add_row(OP_READ,  5'h04, 32'h0,         4'h0, 32'hFFFF_007F);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial
  begin
    row_t      row;
    axi_data_t rd_val;
    axi_data_t ctrl_model;
    axi_data_t sink_model;
    S_AXI_ARESETN = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    // First reset edge passes inside the status setup
    set_status(32'h0);
    ctrl_model = '0;
    sink_model = '0;
    build_table();
    // Worst row stays well under 20 cycles
    cycle_limit = 32'(rows.size() * 20 + 100);
    repeat (4) @(posedge S_AXI_ACLK);
    #1;
    S_AXI_ARESETN = 1'b1;
    @(negedge S_AXI_ACLK);
    check(64'({s_axi_awready, s_axi_wready, s_axi_arready, s_axi_bvalid, s_axi_rvalid}),
          64'(0), "handshake outputs after reset");
    check_pins(ctrl_model, sink_model);
    @(posedge S_AXI_ACLK);
    #1;
    for (int r = 0; r < rows.size(); r++)
    begin
      row = rows[r];
      case (row.op)
        OP_WRITE:
        begin
          axi_write(row.addr, row.data, row.strb);
          // Only slots 0 and 2 feed pins
          if (row.addr[`SYS_REG_ADDR_W-1:`SYS_REG_ADDR_LSB] == 3'd0)
          begin
            ctrl_model = apply_strobes(ctrl_model, row.data, row.strb);
          end
          else if (row.addr[`SYS_REG_ADDR_W-1:`SYS_REG_ADDR_LSB] == 3'd2)
          begin
            sink_model = apply_strobes(sink_model, row.data, row.strb);
          end
        end
        OP_READ:
        begin
          axi_read(row.addr, rd_val);
          check(64'(rd_val), 64'(row.exp), $sformatf("read data, row %0d", r));
        end
        default:
          set_status(row.data);
      endcase
      check_pins(ctrl_model, sink_model);
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/sys_reg_pkg.sv
rtl/axil_write_ctrl.sv
rtl/axil_read_ctrl.sv
rtl/srio_reg_bank.sv
rtl/sys_reg.sv
sim/tb_sys_reg.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the testbench with Verilator
# Exit status is nonzero when the build fails or the run ends in $fatal
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_sys_reg \
  -Mdir obj_dir -o tb_sys_reg \
  && ./obj_dir/tb_sys_reg \
  || { echo "Simulation did not complete successfully" >&2; exit 1; }
